// ==== common/rob_pkg.sv ====
package rob_pkg;

  // Datapath widths
  localparam int data_w = 32;
  localparam int reg_w  = 5;

  // Operation codes seen on the issue port
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_XOR,
    OP_MUL
  } op_t;

  // One reorder-buffer slot payload
  typedef struct packed {
    logic [data_w-1:0] result;
    logic [reg_w-1:0]  dest;
    logic              dest_valid;
  } rob_entry_t;

endpackage

// ==== common/wb_if.sv ====
`timescale 1ns/1ps

interface wb_if #(
  parameter int TAG_W = 3
);

  logic                        valid;
  logic [TAG_W-1:0]            tag;
  logic [rob_pkg::data_w-1:0]  result;
  logic [rob_pkg::reg_w-1:0]   dest;
  logic                        dest_valid;

  // Execution lane side
  modport lane (
    output valid,
    output tag,
    output result,
    output dest,
    output dest_valid
  );

  // Reorder buffer side
  modport rob (
    input valid,
    input tag,
    input result,
    input dest,
    input dest_valid
  );

endinterface

// ==== rob/rob.sv ====
`timescale 1ns/1ps

module rob #(
  parameter int DEPTH = 8
) (
  input  logic                     clock,
  input  logic                     reset_n,

  input  logic                     reserve_i,
  input  rob_pkg::rob_entry_t      reserve_entry_i,
  output logic [$clog2(DEPTH)-1:0] alloc_tag_o,
  output logic                     full_o,

  wb_if.rob                        wb_alu,
  wb_if.rob                        wb_mul,

  input  logic                     flush_i,
  input  logic [$clog2(DEPTH)-1:0] flush_tag_i,

  output logic                     retire_valid_o,
  input  logic                     retire_ready_i,
  output logic [$clog2(DEPTH)-1:0] retire_tag_o,
  output rob_pkg::rob_entry_t      retire_entry_o,
  output logic                     retire_kill_o
);

  localparam int TAG_W = $clog2(DEPTH);

  rob_pkg::rob_entry_t buffer [DEPTH];
  logic [DEPTH-1:0]    valid_q;
  logic [DEPTH-1:0]    kill_q;
  logic [DEPTH-1:0]    kill_set;

  logic [TAG_W-1:0]    ins_ptr;
  logic [TAG_W-1:0]    head_ptr;
  logic [TAG_W:0]      used;
  logic [TAG_W-1:0]    flush_age;

  logic                empty;
  logic                do_reserve;
  logic                do_retire;

  assign empty      = (used == '0);
  assign full_o     = (used == DEPTH[TAG_W:0]);
  assign do_reserve = reserve_i && !full_o;
  assign do_retire  = retire_valid_o && retire_ready_i;

  assign alloc_tag_o = ins_ptr;

  // Head slot drives the retire port directly
  assign retire_valid_o = !empty && (valid_q[head_ptr] || kill_q[head_ptr]);
  assign retire_tag_o   = head_ptr;
  assign retire_entry_o = buffer[head_ptr];
  assign retire_kill_o  = kill_q[head_ptr];

  // Ages are measured from the head, so a full buffer is handled too
  assign flush_age = flush_tag_i - head_ptr;

  always_comb begin
    logic [TAG_W-1:0] age;
    for (int i = 0; i < DEPTH; i++) begin
      age         = TAG_W'(i) - head_ptr;
      kill_set[i] = flush_i && (age > flush_age) && ({1'b0, age} < used);
    end
  end

  // Slot status bits
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
      kill_q  <= '0;
    end else begin
      kill_q <= kill_q | kill_set;
      if (do_reserve) begin
        valid_q[ins_ptr] <= 1'b0;
        kill_q[ins_ptr]  <= 1'b0;
      end
      if (wb_alu.valid)
        valid_q[wb_alu.tag] <= 1'b1;
      if (wb_mul.valid)
        valid_q[wb_mul.tag] <= 1'b1;
    end
  end

  // Entry storage, both lanes may write in the same cycle
  always_ff @(posedge clock) begin
    if (do_reserve)
      buffer[ins_ptr] <= reserve_entry_i;
    if (wb_alu.valid) begin
      buffer[wb_alu.tag].result     <= wb_alu.result;
      buffer[wb_alu.tag].dest       <= wb_alu.dest;
      buffer[wb_alu.tag].dest_valid <= wb_alu.dest_valid;
    end
    if (wb_mul.valid) begin
      buffer[wb_mul.tag].result     <= wb_mul.result;
      buffer[wb_mul.tag].dest       <= wb_mul.dest;
      buffer[wb_mul.tag].dest_valid <= wb_mul.dest_valid;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      ins_ptr  <= '0;
      head_ptr <= '0;
      used     <= '0;
    end else begin
      if (do_reserve)
        ins_ptr <= ins_ptr + 1'b1;
      if (do_retire)
        head_ptr <= head_ptr + 1'b1;
      case ({do_reserve, do_retire})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the reorder-buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module tb_ooo_backend -f vlog.f
./obj_dir/Vtb_ooo_backend

// ==== tb/tb_ooo_backend.sv ====
`timescale 1ns/1ps

module tb_ooo_backend;

  localparam int DEPTH    = 8;
  localparam int TAG_W    = $clog2(DEPTH);
  localparam int NUM_OPS  = 400;
  localparam int TIMEOUT  = NUM_OPS * 40;
  localparam int MUL_DONE = 20;
  localparam logic [31:0] SEED = 32'h50e22da1;

  typedef struct packed {
    logic [TAG_W-1:0]           tag;
    logic [rob_pkg::data_w-1:0] data;
    logic [rob_pkg::reg_w-1:0]  dest;
    logic                       dest_valid;
    logic                       is_mul;
    logic                       kill;
    logic [31:0]                issue_cycle;
  } model_entry_t;

  logic                       clock = 1'b0;
  logic                       reset_n;
  logic                       issue_valid_i;
  logic                       issue_ready_o;
  rob_pkg::op_t               issue_op_i;
  logic [rob_pkg::data_w-1:0] issue_a_i;
  logic [rob_pkg::data_w-1:0] issue_b_i;
  logic [rob_pkg::reg_w-1:0]  issue_dest_i;
  logic                       issue_dest_valid_i;
  logic [TAG_W-1:0]           issue_tag_o;
  logic                       retire_valid_o;
  logic                       retire_ready_i;
  logic [TAG_W-1:0]           retire_tag_o;
  logic [rob_pkg::data_w-1:0] retire_data_o;
  logic [rob_pkg::reg_w-1:0]  retire_dest_o;
  logic                       retire_dest_valid_o;
  logic                       retire_kill_o;
  logic                       flush_i;
  logic [TAG_W-1:0]           flush_tag_i;

  // Reference model state with the oldest entry at the front
  model_entry_t     model_q[$];
  logic [TAG_W-1:0] next_tag = '0;
  logic             issue_fired = 1'b0;
  int               flush_index = 0;
  int               issued = 0;
  int               retired = 0;
  int               sample_cycle = 0;
  int               cycle_count = 0;
  int               stall_left = 0;
  int               full_cycles = 0;
  int               flushes = 0;
  int               kills_seen = 0;

  ooo_backend #(.DEPTH(DEPTH)) u_dut (
    .clock, .reset_n,
    .issue_valid_i, .issue_ready_o, .issue_op_i, .issue_a_i, .issue_b_i,
    .issue_dest_i, .issue_dest_valid_i, .issue_tag_o,
    .retire_valid_o, .retire_ready_i, .retire_tag_o, .retire_data_o,
    .retire_dest_o, .retire_dest_valid_o, .retire_kill_o,
    .flush_i, .flush_tag_i
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      $display("TEST FAIL");
      $fatal(1, "Timeout: only %0d of %0d operations retired after %0d cycles",
             retired, NUM_OPS, cycle_count);
    end
  end

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  function automatic logic [rob_pkg::data_w-1:0] expected_result(
    input rob_pkg::op_t op, input logic [31:0] a, input logic [31:0] b);
    case (op)
      rob_pkg::OP_ADD: return a + b;
      rob_pkg::OP_SUB: return a - b;
      rob_pkg::OP_AND: return a & b;
      rob_pkg::OP_XOR: return a ^ b;
      default:         return 32'(a[15:0]) * 32'(b[15:0]);
    endcase
  endfunction

  // Roughly one multiply in five
  function automatic rob_pkg::op_t random_op();
    if ($urandom_range(0, 4) == 0)
      return rob_pkg::OP_MUL;
    case ($urandom_range(0, 3))
      0:       return rob_pkg::OP_ADD;
      1:       return rob_pkg::OP_SUB;
      2:       return rob_pkg::OP_AND;
      default: return rob_pkg::OP_XOR;
    endcase
  endfunction

  task automatic drive_inputs();
    int min_k;
    // Payload is held until the transfer
    if (!issue_valid_i || issue_fired) begin
      issue_valid_i = 1'b0;
      if (issued < NUM_OPS && $urandom_range(0, 3) != 0) begin
        issue_valid_i      = 1'b1;
        issue_op_i         = random_op();
        issue_a_i          = $urandom();
        issue_b_i          = $urandom();
        issue_dest_i       = 5'($urandom());
        issue_dest_valid_i = ($urandom_range(0, 7) != 0);
      end
    end
    // In-flight multiplies stay alive since a killed slot may be reused before writeback
    flush_i = 1'b0;
    if (model_q.size() != 0 && $urandom_range(0, 29) == 0) begin
      min_k = 0;
      foreach (model_q[i]) begin
        if (model_q[i].is_mul && sample_cycle < model_q[i].issue_cycle + MUL_DONE)
          min_k = i;
      end
      flush_index = min_k + $urandom_range(0, model_q.size() - 1 - min_k);
      flush_i     = 1'b1;
      flush_tag_i = model_q[flush_index].tag;
    end
    if (stall_left > 0) begin
      retire_ready_i = 1'b0;
      stall_left--;
    end else if ($urandom_range(0, 59) == 0) begin
      retire_ready_i = 1'b0;
      stall_left     = 3 * DEPTH;
    end else begin
      retire_ready_i = ($urandom_range(0, 3) != 0);
    end
  endtask

  task automatic sample_outputs();
    model_entry_t entry;
    logic         retire_fire;
    sample_cycle++;
    issue_fired = issue_valid_i && issue_ready_o;
    retire_fire = retire_valid_o && retire_ready_i;

    if (model_q.size() == DEPTH) begin
      full_cycles++;
      check(64'(issue_ready_o), 64'(1'b0), "issue_ready_o high with a full buffer");
    end else if (flush_i) begin
      check(64'(issue_ready_o), 64'(1'b0), "issue_ready_o high during flush");
    end else if (issue_op_i != rob_pkg::OP_MUL) begin
      check(64'(issue_ready_o), 64'(1'b1), "issue_ready_o low with free slots");
    end
    if (model_q.size() == 0)
      check(64'(retire_valid_o), 64'(1'b0), "retire_valid_o high with an empty buffer");

    // Everything younger than the flush slot is killed
    if (flush_i) begin
      flushes++;
      for (int i = flush_index + 1; i < model_q.size(); i++)
        model_q[i].kill = 1'b1;
    end

    if (retire_fire) begin
      entry = model_q.pop_front();
      check(64'(retire_tag_o), 64'(entry.tag), "retire tag");
      check(64'(retire_kill_o), 64'(entry.kill), "retire kill flag");
      if (!entry.kill) begin
        check(64'(retire_data_o), 64'(entry.data), "retire data");
        check(64'(retire_dest_o), 64'(entry.dest), "retire destination");
        check(64'(retire_dest_valid_o), 64'(entry.dest_valid), "retire destination valid");
      end else begin
        kills_seen++;
      end
      retired++;
    end

    if (issue_fired) begin
      check(64'(issue_tag_o), 64'(next_tag), "issue tag");
      entry.tag         = next_tag;
      entry.data        = expected_result(issue_op_i, issue_a_i, issue_b_i);
      entry.dest        = issue_dest_i;
      entry.dest_valid  = issue_dest_valid_i;
      entry.is_mul      = (issue_op_i == rob_pkg::OP_MUL);
      entry.kill        = 1'b0;
      entry.issue_cycle = 32'(sample_cycle);
      model_q.push_back(entry);
      next_tag = next_tag + 1'b1;
      issued++;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    reset_n            = 1'b0;
    issue_valid_i      = 1'b0;
    issue_op_i         = rob_pkg::OP_ADD;
    issue_a_i          = '0;
    issue_b_i          = '0;
    issue_dest_i       = '0;
    issue_dest_valid_i = 1'b0;
    retire_ready_i     = 1'b0;
    flush_i            = 1'b0;
    flush_tag_i        = '0;
    repeat (10) @(posedge clock);
    #1 reset_n = 1'b1;
    #1;
    check(64'(issue_ready_o), 64'(1'b1), "issue_ready_o after reset");
    check(64'(retire_valid_o), 64'(1'b0), "retire_valid_o after reset");

    while (retired < NUM_OPS) begin
      @(posedge clock);
      #1;
      drive_inputs();
      #1;
      sample_outputs();
    end

    check(64'(full_cycles != 0), 64'(1'b1), "buffer never filled under back-pressure");
    check(64'(flushes != 0), 64'(1'b1), "no flush was applied");
    check(64'(kills_seen != 0), 64'(1'b1), "no killed entry retired");
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== verilog/alu_lane.sv ====
`timescale 1ns/1ps

module alu_lane #(
  parameter int TAG_W = 3
) (
  input  logic                        clock,
  input  logic                        reset_n,
  input  logic                        start_i,
  input  rob_pkg::op_t                op_i,
  input  logic [rob_pkg::data_w-1:0]  a_i,
  input  logic [rob_pkg::data_w-1:0]  b_i,
  input  logic [TAG_W-1:0]            tag_i,
  input  logic [rob_pkg::reg_w-1:0]   dest_i,
  input  logic                        dest_valid_i,
  wb_if.lane                          wb
);

  // Stage one registers
  logic                        s1_valid;
  rob_pkg::op_t                s1_op;
  logic [rob_pkg::data_w-1:0]  s1_a;
  logic [rob_pkg::data_w-1:0]  s1_b;
  logic [TAG_W-1:0]            s1_tag;
  logic [rob_pkg::reg_w-1:0]   s1_dest;
  logic                        s1_dest_valid;
  logic [rob_pkg::data_w-1:0]  s2_result;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      s1_valid <= 1'b0;
      wb.valid <= 1'b0;
    end else begin
      s1_valid <= start_i;
      wb.valid <= s1_valid;
    end
  end

  always_ff @(posedge clock) begin
    s1_op         <= op_i;
    s1_a          <= a_i;
    s1_b          <= b_i;
    s1_tag        <= tag_i;
    s1_dest       <= dest_i;
    s1_dest_valid <= dest_valid_i;
    wb.result     <= s2_result;
    wb.tag        <= s1_tag;
    wb.dest       <= s1_dest;
    wb.dest_valid <= s1_dest_valid;
  end

  always_comb begin
    case (s1_op)
      rob_pkg::OP_ADD: s2_result = s1_a + s1_b;
      rob_pkg::OP_SUB: s2_result = s1_a - s1_b;
      rob_pkg::OP_AND: s2_result = s1_a & s1_b;
      rob_pkg::OP_XOR: s2_result = s1_a ^ s1_b;
      default:         s2_result = '0;
    endcase
  end

endmodule

// ==== verilog/dispatch.sv ====
`timescale 1ns/1ps

module dispatch #(
  parameter int DEPTH = 8
) (
  input  logic                        clock,
  input  logic                        reset_n,

  input  logic                        issue_valid_i,
  output logic                        issue_ready_o,
  input  rob_pkg::op_t                issue_op_i,
  input  logic [rob_pkg::data_w-1:0]  issue_a_i,
  input  logic [rob_pkg::data_w-1:0]  issue_b_i,
  input  logic [rob_pkg::reg_w-1:0]   issue_dest_i,
  input  logic                        issue_dest_valid_i,
  output logic [$clog2(DEPTH)-1:0]    issue_tag_o,

  input  logic [$clog2(DEPTH)-1:0]    alloc_tag_i,
  input  logic                        full_i,
  input  logic                        mul_busy_i,
  input  logic                        flush_i,

  output logic                        reserve_o,
  output rob_pkg::rob_entry_t         reserve_entry_o,
  output logic                        alu_start_o,
  output logic                        mul_start_o,
  output rob_pkg::op_t                op_o,
  output logic [rob_pkg::data_w-1:0]  a_o,
  output logic [rob_pkg::data_w-1:0]  b_o,
  output logic [$clog2(DEPTH)-1:0]    tag_o,
  output logic [rob_pkg::reg_w-1:0]   dest_o,
  output logic                        dest_valid_o
);

  logic is_mul;
  logic fire;
  logic mul_guard;

  assign is_mul = (issue_op_i == rob_pkg::OP_MUL);

  // Multiplier takes one operation at a time
  assign issue_ready_o = !full_i && !flush_i && (!is_mul || !(mul_busy_i || mul_guard));
  assign fire          = issue_valid_i && issue_ready_o;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      mul_guard <= 1'b0;
    else
      mul_guard <= mul_start_o;
  end

  assign reserve_o                  = fire;
  assign reserve_entry_o.result     = '0;
  assign reserve_entry_o.dest       = issue_dest_i;
  assign reserve_entry_o.dest_valid = issue_dest_valid_i;

  assign alu_start_o = fire && !is_mul;
  assign mul_start_o = fire && is_mul;

  // Operands go to both lanes, the start pulse picks one
  assign op_o         = issue_op_i;
  assign a_o          = issue_a_i;
  assign b_o          = issue_b_i;
  assign tag_o        = alloc_tag_i;
  assign dest_o       = issue_dest_i;
  assign dest_valid_o = issue_dest_valid_i;
  assign issue_tag_o  = alloc_tag_i;

endmodule

// ==== verilog/mul_lane.sv ====
`timescale 1ns/1ps

module mul_lane #(
  parameter int TAG_W = 3
) (
  input  logic                        clock,
  input  logic                        reset_n,
  input  logic                        start_i,
  input  logic [rob_pkg::data_w-1:0]  a_i,
  input  logic [rob_pkg::data_w-1:0]  b_i,
  input  logic [TAG_W-1:0]            tag_i,
  input  logic [rob_pkg::reg_w-1:0]   dest_i,
  input  logic                        dest_valid_i,
  output logic                        busy_o,
  wb_if.lane                          wb
);

  logic [3:0]                  steps_left;
  logic [rob_pkg::data_w-1:0]  acc;
  logic [rob_pkg::data_w-1:0]  mcand;
  logic [15:0]                 mplier;

  // Control
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      busy_o     <= 1'b0;
      wb.valid   <= 1'b0;
      steps_left <= '0;
    end else begin
      wb.valid <= 1'b0;
      if (start_i && !busy_o) begin
        busy_o     <= 1'b1;
        steps_left <= 4'd15;
      end else if (busy_o) begin
        if (steps_left != '0) begin
          steps_left <= steps_left - 1'b1;
        end else begin
          busy_o   <= 1'b0;
          wb.valid <= 1'b1;
        end
      end
    end
  end

  // Datapath, the first partial product is taken when loading
  always_ff @(posedge clock) begin
    if (start_i && !busy_o) begin
      acc           <= b_i[0] ? {16'b0, a_i[15:0]} : '0;
      mcand         <= {15'b0, a_i[15:0], 1'b0};
      mplier        <= {1'b0, b_i[15:1]};
      wb.tag        <= tag_i;
      wb.dest       <= dest_i;
      wb.dest_valid <= dest_valid_i;
    end else if (busy_o && steps_left != '0) begin
      if (mplier[0])
        acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Product is final once the step counter runs out
  always_ff @(posedge clock) begin
    if (busy_o && steps_left == '0)
      wb.result <= acc;
  end

endmodule

// ==== verilog/ooo_backend.sv ====
`timescale 1ns/1ps

module ooo_backend #(
  parameter int DEPTH = 8
) (
  input  logic                        clock,
  input  logic                        reset_n,

  input  logic                        issue_valid_i,
  output logic                        issue_ready_o,
  input  rob_pkg::op_t                issue_op_i,
  input  logic [rob_pkg::data_w-1:0]  issue_a_i,
  input  logic [rob_pkg::data_w-1:0]  issue_b_i,
  input  logic [rob_pkg::reg_w-1:0]   issue_dest_i,
  input  logic                        issue_dest_valid_i,
  output logic [$clog2(DEPTH)-1:0]    issue_tag_o,

  output logic                        retire_valid_o,
  input  logic                        retire_ready_i,
  output logic [$clog2(DEPTH)-1:0]    retire_tag_o,
  output logic [rob_pkg::data_w-1:0]  retire_data_o,
  output logic [rob_pkg::reg_w-1:0]   retire_dest_o,
  output logic                        retire_dest_valid_o,
  output logic                        retire_kill_o,

  input  logic                        flush_i,
  input  logic [$clog2(DEPTH)-1:0]    flush_tag_i
);

  localparam int TAG_W = $clog2(DEPTH);

  logic                        reserve;
  rob_pkg::rob_entry_t         reserve_entry;
  logic [TAG_W-1:0]            alloc_tag;
  logic                        full;
  logic                        mul_busy;
  logic                        alu_start;
  logic                        mul_start;
  rob_pkg::op_t                op;
  logic [rob_pkg::data_w-1:0]  a;
  logic [rob_pkg::data_w-1:0]  b;
  logic [TAG_W-1:0]            tag;
  logic [rob_pkg::reg_w-1:0]   dest;
  logic                        dest_valid;
  rob_pkg::rob_entry_t         retire_entry;

  wb_if #(.TAG_W(TAG_W)) wb_alu ();
  wb_if #(.TAG_W(TAG_W)) wb_mul ();

  dispatch #(.DEPTH(DEPTH)) u_dispatch (
    .clock, .reset_n,
    .issue_valid_i, .issue_ready_o, .issue_op_i, .issue_a_i, .issue_b_i,
    .issue_dest_i, .issue_dest_valid_i, .issue_tag_o,
    .alloc_tag_i (alloc_tag), .full_i (full), .mul_busy_i (mul_busy), .flush_i,
    .reserve_o (reserve), .reserve_entry_o (reserve_entry),
    .alu_start_o (alu_start), .mul_start_o (mul_start),
    .op_o (op), .a_o (a), .b_o (b), .tag_o (tag),
    .dest_o (dest), .dest_valid_o (dest_valid)
  );

  alu_lane #(.TAG_W(TAG_W)) u_alu_lane (
    .clock, .reset_n, .start_i (alu_start), .op_i (op), .a_i (a), .b_i (b),
    .tag_i (tag), .dest_i (dest), .dest_valid_i (dest_valid), .wb (wb_alu.lane)
  );

  mul_lane #(.TAG_W(TAG_W)) u_mul_lane (
    .clock, .reset_n, .start_i (mul_start), .a_i (a), .b_i (b), .tag_i (tag),
    .dest_i (dest), .dest_valid_i (dest_valid), .busy_o (mul_busy), .wb (wb_mul.lane)
  );

  rob #(.DEPTH(DEPTH)) u_rob (
    .clock, .reset_n,
    .reserve_i (reserve), .reserve_entry_i (reserve_entry),
    .alloc_tag_o (alloc_tag), .full_o (full),
    .wb_alu (wb_alu.rob), .wb_mul (wb_mul.rob),
    .flush_i, .flush_tag_i,
    .retire_valid_o, .retire_ready_i, .retire_tag_o,
    .retire_entry_o (retire_entry), .retire_kill_o
  );

  assign retire_data_o       = retire_entry.result;
  assign retire_dest_o       = retire_entry.dest;
  assign retire_dest_valid_o = retire_entry.dest_valid;

endmodule

// ==== vlog.f ====
common/rob_pkg.sv
common/wb_if.sv
verilog/alu_lane.sv
verilog/mul_lane.sv
verilog/dispatch.sv
rob/rob.sv
verilog/ooo_backend.sv
tb/tb_ooo_backend.sv
